//--- list.f
common/mbusPkg.sv
hw/wireCtrl/mbusWireCtrl.sv
hw/sleepCtrl/mbusSleepCtrl.sv
hw/busCtrl/mbusBusCtrl.sv
hw/mbusNode.sv
verif/mbusNodeChecker.sv
verif/mbusNodeTb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing
LINTFLAGS := --lint-only --timing -Wall
TOP       := mbusNodeTb
FILELIST  := list.f
BUILDDIR  := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILDDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BUILDDIR)/V$(TOP)
	$(BUILDDIR)/V$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)

//--- verif/mbusNodeTb.sv
// Testbench for the MBus member node: clock, reset and a table of frame, sleep
// and interrupt tests applied in a loop; mbusNodeChecker does the comparing.

`timescale 1ns/1ps

module mbusNodeTb
  import mbusPkg::*;
();

  localparam int clkPeriod     = 8;
  localparam int timeoutCycles = 40;
  localparam int numTests      = 12;
  localparam logic [addrWidth-1:0] ownAddr = 4'h5;

  // Test modes
  localparam logic [2:0] modeForward = 3'd0;
  localparam logic [2:0] modeReceive = 3'd1;
  localparam logic [2:0] modeSend    = 3'd2;
  localparam logic [2:0] modeSleep   = 3'd3;
  localparam logic [2:0] modeInt     = 3'd4;

  // For sleep entries a nonzero addr wakes the node by pulling din low
  typedef struct packed {
    logic [8*12-1:0]      name;
    logic [2:0]           mode;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] data;
  } stimEntry;

  stimEntry tests [numTests];

  logic                 CLKOUT_FROM_BUS = 1'b0;
  logic                 RESETn;
  logic                 din;
  logic                 clkIn;
  logic                 sleepReq;
  logic                 externalInt;
  logic [addrWidth-1:0] nodeAddr;
  logic                 txReq;
  logic [addrWidth-1:0] txAddr;
  logic [dataWidth-1:0] txData;
  logic                 dout;
  logic                 clkOut;
  logic                 rxValid;
  logic [dataWidth-1:0] rxData;
  logic                 txDone;
  logic                 frameStart;
  logic [8*12-1:0]      curName;
  logic [31:0]          rngState;
  int                   mismatches;
  int                   timeouts;

  always #(clkPeriod / 2) CLKOUT_FROM_BUS = ~CLKOUT_FROM_BUS;

  mbusNode UUT (
    .CLKOUT_FROM_BUS (CLKOUT_FROM_BUS),
    .RESETn          (RESETn),
    .din             (din),
    .clkIn           (clkIn),
    .sleepReq        (sleepReq),
    .externalInt     (externalInt),
    .nodeAddr        (nodeAddr),
    .txReq           (txReq),
    .txAddr          (txAddr),
    .txData          (txData),
    .dout            (dout),
    .clkOut          (clkOut),
    .rxValid         (rxValid),
    .rxData          (rxData),
    .txDone          (txDone)
  );

  mbusNodeChecker ruleCheck (
    .CLKOUT_FROM_BUS (CLKOUT_FROM_BUS),
    .RESETn          (RESETn),
    .din             (din),
    .clkIn           (clkIn),
    .sleepReq        (sleepReq),
    .externalInt     (externalInt),
    .nodeAddr        (nodeAddr),
    .txReq           (txReq),
    .txAddr          (txAddr),
    .txData          (txData),
    .dout            (dout),
    .clkOut          (clkOut),
    .rxValid         (rxValid),
    .rxData          (rxData),
    .txDone          (txDone),
    .frameStart      (frameStart),
    .testName        (curName),
    .errors          (mismatches)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic loadTests();
    tests[0]  = '{"forwardA", modeForward, 4'h3, 8'hA5};
    tests[1]  = '{"receiveA", modeReceive, ownAddr, 8'h3C};
    tests[2]  = '{"sendA", modeSend, 4'h9, 8'hC3};
    tests[3]  = '{"forwardNear", modeForward, 4'h4, 8'hE7};
    tests[4]  = '{"receiveB", modeReceive, ownAddr, 8'hFF};
    tests[5]  = '{"sendB", modeSend, 4'h0, 8'h00};
    tests[6]  = '{"sleepHold", modeSleep, 4'h0, 8'h00};
    tests[7]  = '{"intIsolated", modeInt, 4'h0, 8'h00};
    tests[8]  = '{"forwardWake", modeForward, 4'hA, 8'h5A};
    tests[9]  = '{"intAwake", modeInt, 4'h0, 8'h00};
    tests[10] = '{"sleepDinWake", modeSleep, 4'h1, 8'h00};
    tests[11] = '{"receiveWake", modeReceive, ownAddr, 8'h81};
  endtask

  // Start bit, address and data on din, one bit per rising edge
  task automatic driveFrame(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
    logic [frameBits-1:0] bits;
    logic                 first;
    bits  = {1'b0, addr, data};
    first = 1'b1;
    repeat (frameBits) begin
      @(posedge CLKOUT_FROM_BUS);
      din        <= bits[frameBits-1];
      frameStart <= first;
      bits       = {bits[frameBits-2:0], 1'b1};
      first      = 1'b0;
    end
    @(posedge CLKOUT_FROM_BUS);
    din        <= 1'b1;
    frameStart <= 1'b0;
  endtask

  task automatic waitForPulse(input logic wantTx, input string what);
    int   cycles;
    logic hit;
    hit = 1'b0;
    for (cycles = 0; cycles < timeoutCycles && !hit; cycles++) begin
      @(negedge CLKOUT_FROM_BUS);
      hit = wantTx ? txDone : rxValid;
    end
    if (!hit) begin
      timeouts++;
      $display("ERROR: test %0s got no %0s pulse within %0d cycles", curName, what, timeoutCycles);
    end
  endtask

  // clkOut stops following clkIn (held at 1) once the node is awake
  task automatic waitAwake();
    int   cycles;
    logic hit;
    hit = 1'b0;
    for (cycles = 0; cycles < timeoutCycles && !hit; cycles++) begin
      @(negedge CLKOUT_FROM_BUS);
      #2;
      hit = (clkOut !== clkIn);
    end
    if (!hit) begin
      timeouts++;
      $display("ERROR: test %0s, node did not wake up within %0d cycles", curName, timeoutCycles);
    end
  endtask

  task automatic applyEntry(input stimEntry t);
    @(posedge CLKOUT_FROM_BUS);
    curName <= t.name;
    case (t.mode)
      modeForward: begin
        driveFrame(t.addr, t.data);
      end
      modeReceive: begin
        driveFrame(t.addr, t.data);
        waitForPulse(1'b0, "rxValid");
      end
      modeSend: begin
        @(posedge CLKOUT_FROM_BUS);
        txReq      <= 1'b1;
        txAddr     <= t.addr;
        txData     <= t.data;
        frameStart <= 1'b1;
        @(posedge CLKOUT_FROM_BUS);
        frameStart <= 1'b0;
        waitForPulse(1'b1, "txDone");
        @(posedge CLKOUT_FROM_BUS);
        txReq <= 1'b0;
      end
      modeSleep: begin
        @(posedge CLKOUT_FROM_BUS);
        sleepReq <= 1'b1;
        @(posedge CLKOUT_FROM_BUS);
        sleepReq <= 1'b0;
        // Random ring clock while isolated
        repeat (10) begin
          @(posedge CLKOUT_FROM_BUS);
          rngState = xorshift32(rngState);
          clkIn <= rngState[0];
        end
        @(posedge CLKOUT_FROM_BUS);
        clkIn <= 1'b1;
        if (t.addr != '0) begin
          @(posedge CLKOUT_FROM_BUS);
          din <= 1'b0;
          @(posedge CLKOUT_FROM_BUS);
          din <= 1'b1;
          waitAwake();
        end
      end
      modeInt: begin
        @(posedge CLKOUT_FROM_BUS);
        externalInt <= 1'b1;
        repeat (2) @(posedge CLKOUT_FROM_BUS);
        externalInt <= 1'b0;
        waitAwake();
      end
    endcase
    repeat (3) @(posedge CLKOUT_FROM_BUS);
  endtask

  initial begin
    RESETn      = 1'b0;
    din         = 1'b0;
    clkIn       = 1'b0;
    sleepReq    = 1'b0;
    externalInt = 1'b0;
    nodeAddr    = ownAddr;
    txReq       = 1'b0;
    txAddr      = '0;
    txData      = '0;
    frameStart  = 1'b0;
    curName     = "reset";
    rngState    = 32'd72;
    timeouts    = 0;
    loadTests();
    repeat (2) @(posedge CLKOUT_FROM_BUS);
    RESETn <= 1'b1;
    din    <= 1'b1;
    clkIn  <= 1'b1;
    repeat (3) @(posedge CLKOUT_FROM_BUS);
    for (int i = 0; i < numTests; i++) begin
      applyEntry(tests[i]);
      if (timeouts != 0) begin
        break;
      end
    end
    $display("Errors: mismatches=%0d timeouts=%0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verif/mbusNodeChecker.sv
// Watches the ports of the MBus node and checks them against the wire, sleep
// and frame rules. The TB marks the first cycle of each frame with frameStart.

`timescale 1ns/1ps

module mbusNodeChecker
  import mbusPkg::*;
(
  input  logic                 CLKOUT_FROM_BUS,
  input  logic                 RESETn,
  input  logic                 din,
  input  logic                 clkIn,
  input  logic                 sleepReq,
  input  logic                 externalInt,
  input  logic [addrWidth-1:0] nodeAddr,
  input  logic                 txReq,
  input  logic [addrWidth-1:0] txAddr,
  input  logic [dataWidth-1:0] txData,
  input  logic                 dout,
  input  logic                 clkOut,
  input  logic                 rxValid,
  input  logic [dataWidth-1:0] rxData,
  input  logic                 txDone,
  input  logic                 frameStart,
  input  logic [8*12-1:0]      testName,
  output int                   errors
);

  int                   errCount = 0;
  sleepState            modelState = sleepAwake;
  int                   relCnt = 0;
  int                   step = 0;
  logic                 active = 1'b0;
  logic                 sending = 1'b0;
  logic                 own = 1'b0;
  logic                 lastDin = 1'b1;
  logic [frameBits-1:0] rxBits = '1;
  logic [frameBits-1:0] txBits = '1;

  assign errors = errCount;

  task automatic checkBit(input string what, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("MISMATCH test=%0s %0s expected=%b actual=%b", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkByte(input string what, input logic [dataWidth-1:0] expVal,
                           input logic [dataWidth-1:0] actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("MISMATCH test=%0s %0s expected=%h actual=%h", testName, what, expVal, actVal);
    end
  endtask

  // Sampled in the low phase, clear of the clock edge that feeds clkOut
  always @(negedge CLKOUT_FROM_BUS) begin
    logic hold;
    logic expDout;
    logic expRx;
    logic expTx;
    #2;
    hold    = (modelState != sleepAwake);
    expDout = 1'b1;
    expRx   = 1'b0;
    expTx   = 1'b0;
    if (!RESETn) begin
      checkBit("dout in reset", 1'b1, dout);
      checkBit("clkOut in reset", 1'b1, clkOut);
      checkBit("rxValid in reset", 1'b0, rxValid);
      checkBit("txDone in reset", 1'b0, txDone);
      modelState = sleepAwake;
      relCnt     = 0;
      active     = 1'b0;
    end else begin
      if (frameStart) begin
        active  = 1'b1;
        step    = 0;
        sending = txReq;
        own     = 1'b0;
        txBits  = {1'b0, txAddr, txData};
      end else if (active) begin
        step++;
      end
      // Address is complete once start plus four bits are in
      if (active && !sending && step == addrWidth + 1) begin
        own = (rxBits[addrWidth-1:0] == nodeAddr);
      end
      if (active && step >= 1) begin
        expDout = sending ? txBits[frameBits-1] : (own ? 1'b1 : lastDin);
        txBits  = {txBits[frameBits-2:0], 1'b1};
      end
      if (active && step < frameBits) begin
        rxBits = {rxBits[frameBits-2:0], din};
      end
      if (active && step == frameBits) begin
        expRx  = own;
        expTx  = sending;
        active = 1'b0;
      end
      if (hold) begin
        expDout = din;
      end
      if (externalInt) begin
        expDout = 1'b0;
      end
      checkBit("dout", expDout, dout);
      checkBit("clkOut", hold ? clkIn : CLKOUT_FROM_BUS, clkOut);
      checkBit("rxValid", expRx, rxValid);
      checkBit("txDone", expTx, txDone);
      if (expRx && rxValid) begin
        checkByte("rxData", rxBits[dataWidth-1:0], rxData);
      end
      // Sleep state the DUT takes on at the next rising edge
      case (modelState)
        sleepAwake: begin
          if (sleepReq) begin
            modelState = sleepIsolated;
          end
        end
        sleepIsolated: begin
          if (externalInt || !din) begin
            modelState = sleepReleasing;
            relCnt     = 0;
          end
        end
        sleepReleasing: begin
          if (relCnt == wakeCycles - 1) begin
            modelState = sleepAwake;
          end else begin
            relCnt++;
          end
        end
        default: begin
          modelState = sleepAwake;
        end
      endcase
    end
    lastDin = din;
  end

endmodule

//--- hw/mbusNode.sv
// Top level of one MBus ring member: bus engine, sleep FSM and output stage.
// Ring pins are din/dout and clkIn/clkOut; the local side is the tx/rx ports.

`timescale 1ns/1ps

module mbusNode
  import mbusPkg::*;
(
  input  logic                 CLKOUT_FROM_BUS,
  input  logic                 RESETn,
  input  logic                 din,
  input  logic                 clkIn,
  input  logic                 sleepReq,
  input  logic                 externalInt,
  input  logic [addrWidth-1:0] nodeAddr,
  input  logic                 txReq,
  input  logic [addrWidth-1:0] txAddr,
  input  logic [dataWidth-1:0] txData,
  output logic                 dout,
  output logic                 clkOut,
  output logic                 rxValid,
  output logic [dataWidth-1:0] rxData,
  output logic                 txDone
);

  logic doutFromBus;
  logic releaseIsoFromSleepCtrl;
  logic busEnable;

  mbusBusCtrl busCtrl (
    .CLKOUT_FROM_BUS (CLKOUT_FROM_BUS),
    .RESETn          (RESETn),
    .busEnable       (busEnable),
    .din             (din),
    .nodeAddr        (nodeAddr),
    .txReq           (txReq),
    .txAddr          (txAddr),
    .txData          (txData),
    .doutFromBus     (doutFromBus),
    .rxValid         (rxValid),
    .rxData          (rxData),
    .txDone          (txDone)
  );

  mbusSleepCtrl sleepCtrl (
    .CLKOUT_FROM_BUS         (CLKOUT_FROM_BUS),
    .RESETn                  (RESETn),
    .sleepReq                (sleepReq),
    .externalInt             (externalInt),
    .din                     (din),
    .releaseIsoFromSleepCtrl (releaseIsoFromSleepCtrl),
    .busEnable               (busEnable)
  );

  mbusWireCtrl wireCtrl (
    .RESETn                  (RESETn),
    .CLKOUT_FROM_BUS         (CLKOUT_FROM_BUS),
    .doutFromBus             (doutFromBus),
    .din                     (din),
    .clkIn                   (clkIn),
    .releaseIsoFromSleepCtrl (releaseIsoFromSleepCtrl),
    .externalInt             (externalInt),
    .dout                    (dout),
    .clkOut                  (clkOut)
  );

endmodule

//--- hw/busCtrl/mbusBusCtrl.sv
// Bit-serial frame engine of the node: forwards foreign frames one cycle late,
// consumes frames for nodeAddr and serializes local transmit requests.

`timescale 1ns/1ps

module mbusBusCtrl
  import mbusPkg::*;
(
  input  logic                 CLKOUT_FROM_BUS,
  input  logic                 RESETn,
  input  logic                 busEnable,
  input  logic                 din,
  input  logic [addrWidth-1:0] nodeAddr,
  input  logic                 txReq,
  input  logic [addrWidth-1:0] txAddr,
  input  logic [dataWidth-1:0] txData,
  output logic                 doutFromBus,
  output logic                 rxValid,
  output logic [dataWidth-1:0] rxData,
  output logic                 txDone
);

  busState state;

  logic [cntWidth-1:0]  bitCnt;
  logic                 consume;
  logic [addrWidth-1:0] addrShift;
  logic [dataWidth-1:0] dataShift;
  logic [frameBits-2:0] txShift;

  logic [addrWidth-1:0] addrNext;
  logic [dataWidth-1:0] dataNext;
  logic                 lastAddr;
  logic                 lastData;
  logic                 lastSend;
  logic                 txStart;
  logic                 rxDone;

  // Word as it stands once the current bit is shifted in
  assign addrNext = {addrShift[addrWidth-2:0], din};
  assign dataNext = {dataShift[dataWidth-2:0], din};

  assign lastAddr = (bitCnt == cntWidth'(addrWidth - 1));
  assign lastData = (bitCnt == cntWidth'(dataWidth - 1));
  assign lastSend = (bitCnt == cntWidth'(frameBits - 2));

  // Send only on a quiet line, and not in the cycle that just finished a frame
  assign txStart = busEnable && (state == busIdle) && din && txReq && !txDone;

  assign rxDone = busEnable && (state == busData) && lastData && consume;

  always_ff @(posedge CLKOUT_FROM_BUS or negedge RESETn) begin
    if (!RESETn) begin
      state       <= busIdle;
      bitCnt      <= '0;
      consume     <= 1'b0;
      doutFromBus <= 1'b1;
      rxValid     <= 1'b0;
      txDone      <= 1'b0;
    end else if (!busEnable) begin
      // Asleep or waking up, keep the line released
      state       <= busIdle;
      bitCnt      <= '0;
      consume     <= 1'b0;
      doutFromBus <= 1'b1;
      rxValid     <= 1'b0;
      txDone      <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      txDone  <= 1'b0;
      case (state)
        busIdle: begin
          bitCnt  <= '0;
          consume <= 1'b0;
          if (!din) begin
            // Start bit, forwarded like every other received bit
            doutFromBus <= 1'b0;
            state       <= busAddr;
          end else if (txStart) begin
            doutFromBus <= 1'b0;
            state       <= busSend;
          end else begin
            doutFromBus <= din;
          end
        end
        busAddr: begin
          if (lastAddr) begin
            bitCnt  <= '0;
            consume <= (addrNext == nodeAddr);
            state   <= busData;
            // Our own frame stops here
            doutFromBus <= (addrNext == nodeAddr) ? 1'b1 : din;
          end else begin
            bitCnt      <= bitCnt + 1'b1;
            doutFromBus <= din;
          end
        end
        busData: begin
          doutFromBus <= consume ? 1'b1 : din;
          if (lastData) begin
            bitCnt  <= '0;
            rxValid <= consume;
            state   <= busIdle;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        busSend: begin
          doutFromBus <= txShift[frameBits-2];
          if (lastSend) begin
            bitCnt <= '0;
            txDone <= 1'b1;
            state  <= busIdle;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
        default: begin
          state       <= busIdle;
          doutFromBus <= 1'b1;
        end
      endcase
    end
  end

  // Shift registers and received byte
  always_ff @(posedge CLKOUT_FROM_BUS) begin
    if (txStart) begin
      txShift <= {txAddr, txData};
    end else if (state == busSend) begin
      txShift <= {txShift[frameBits-3:0], 1'b0};
    end
    if (state == busAddr) begin
      addrShift <= addrNext;
    end
    if (state == busData) begin
      dataShift <= dataNext;
    end
    if (rxDone) begin
      rxData <= dataNext;
    end
  end

endmodule

//--- hw/sleepCtrl/mbusSleepCtrl.sv
// Sleep and wake FSM; isolates the node on request and releases it
// on an interrupt or a falling edge of ring activity on din.

`timescale 1ns/1ps

module mbusSleepCtrl
  import mbusPkg::*;
(
  input  logic CLKOUT_FROM_BUS,
  input  logic RESETn,
  input  logic sleepReq,
  input  logic externalInt,
  input  logic din,
  output logic releaseIsoFromSleepCtrl,
  output logic busEnable
);

  sleepState state;
  sleepState stateNext;

  logic [wakeCntWidth-1:0] wakeCnt;
  logic                    wakeDone;

  // Last cycle of the releasing window
  assign wakeDone = (wakeCnt == wakeCntWidth'(wakeCycles - 1));

  always_comb begin
    stateNext = state;
    case (state)
      sleepAwake: begin
        if (sleepReq) begin
          stateNext = sleepIsolated;
        end
      end
      sleepIsolated: begin
        // A start bit on the ring counts as a wake event
        if (externalInt || !din) begin
          stateNext = sleepReleasing;
        end
      end
      sleepReleasing: begin
        if (wakeDone) begin
          stateNext = sleepAwake;
        end
      end
      default: begin
        stateNext = sleepAwake;
      end
    endcase
  end

  always_ff @(posedge CLKOUT_FROM_BUS or negedge RESETn) begin
    if (!RESETn) begin
      state   <= sleepAwake;
      wakeCnt <= '0;
    end else begin
      state <= stateNext;
      if (state == sleepReleasing) begin
        wakeCnt <= wakeCnt + 1'b1;
      end else begin
        wakeCnt <= '0;
      end
    end
  end

  // Hold stays asserted until the wake window has run out
  assign releaseIsoFromSleepCtrl = (state == sleepAwake) ? ~ioHold : ioHold;
  assign busEnable               = (state == sleepAwake);

endmodule

//--- hw/wireCtrl/mbusWireCtrl.sv
// Ring output stage: picks what drives dout and clkOut.
// Reset wins, then the interrupt, then hold pass-through or bus drive.

`timescale 1ns/1ps

module mbusWireCtrl
  import mbusPkg::*;
(
  input  logic RESETn,
  input  logic CLKOUT_FROM_BUS,
  input  logic doutFromBus,
  input  logic din,
  input  logic clkIn,
  input  logic releaseIsoFromSleepCtrl,
  input  logic externalInt,
  output logic dout,
  output logic clkOut
);

  logic inHold;

  assign inHold = (releaseIsoFromSleepCtrl == ioHold);

  always_comb begin
    if (!RESETn) begin
      // Idle ring level on both lines
      dout   = 1'b1;
      clkOut = 1'b1;
    end else begin
      // Interrupt pulls the data line low to wake the ring
      if (externalInt) begin
        dout = 1'b0;
      end else if (inHold) begin
        dout = din;
      end else begin
        dout = doutFromBus;
      end

      // Isolated node passes the ring clock straight through
      clkOut = inHold ? clkIn : CLKOUT_FROM_BUS;
    end
  end

endmodule

//--- common/mbusPkg.sv
// Shared widths, levels and state encodings for the MBus member node.
// Imported by the node blocks with a wildcard import in the module header.

package mbusPkg;

  // Frame layout is start bit, address, then data, MSB first
  localparam int addrWidth = 4;
  localparam int dataWidth = 8;

  // Start bit plus one address word plus one data word
  localparam int frameBits = 1 + addrWidth + dataWidth;

  // Wide enough to count every bit after the start bit
  localparam int cntWidth = $clog2(frameBits);

  // Release level that keeps the node isolated
  localparam logic ioHold = 1'b0;

  // Cycles spent releasing isolation before the bus is enabled again
  localparam int wakeCycles = 2;
  localparam int wakeCntWidth = $clog2(wakeCycles + 1);

  // Power state of the node
  typedef enum logic [1:0] {
    sleepAwake     = 2'd0,
    sleepIsolated  = 2'd1,
    sleepReleasing = 2'd2
  } sleepState;

  // Bit-level state of the bus controller
  typedef enum logic [1:0] {
    busIdle = 2'd0,
    busAddr = 2'd1,
    busData = 2'd2,
    busSend = 2'd3
  } busState;

endpackage
